//--- hw/core_pkg.sv
/*
 * Shared widths and MMIO address map of the core peripheral block
 * Interrupt cause codes and the trap vector word with its two views
 */

package core_pkg;

    // Bus widths
    // --------------------------------------------------
    localparam int XLEN       = 32;                       // Data and address width
    localparam int MEM_STRB_W = 4;                        // Byte strobes per word

    // MMIO region
    // --------------------------------------------------
    localparam logic [XLEN-1:0] MMIO_BASE_ADDR  = 32'h0000_1000; // Region base
    localparam logic [XLEN-1:0] MMIO_MATCH_MASK = 32'hFFFF_F000; // Bits compared to base

    localparam int MMIO_OFS_W = 12;                       // Offset bits inside region

    localparam logic [MMIO_OFS_W-1:0] MMIO_OFS_MTIME_LO    = 12'h000; // mtime [31:0]
    localparam logic [MMIO_OFS_W-1:0] MMIO_OFS_MTIME_HI    = 12'h004; // mtime [63:32]
    localparam logic [MMIO_OFS_W-1:0] MMIO_OFS_MTIMECMP_LO = 12'h008; // mtimecmp [31:0]
    localparam logic [MMIO_OFS_W-1:0] MMIO_OFS_MTIMECMP_HI = 12'h00C; // mtimecmp [63:32]
    localparam logic [MMIO_OFS_W-1:0] MMIO_OFS_INSTRET_LO  = 12'h010; // instret [31:0]
    localparam logic [MMIO_OFS_W-1:0] MMIO_OFS_INSTRET_HI  = 12'h014; // instret [63:32]

    localparam int CTR_W = 64;                            // Counter width, two halves

    // Interrupt causes and trap vector
    // --------------------------------------------------
    localparam int CAUSE_W = 4;                           // Cause code width

    localparam logic [CAUSE_W-1:0] CAUSE_MSI = 4'd3;      // Machine software
    localparam logic [CAUSE_W-1:0] CAUSE_MTI = 4'd7;      // Machine timer
    localparam logic [CAUSE_W-1:0] CAUSE_MEI = 4'd11;     // Machine external

    localparam logic [1:0] MTVEC_MODE_DIRECT   = 2'd0;    // All traps to base
    localparam logic [1:0] MTVEC_MODE_VECTORED = 2'd1;    // Base plus 4 x cause

    // Word as held by the CSR file, or split into base and mode
    typedef union packed {
        logic [XLEN-1:0] raw;                             // Whole word
        struct packed {
            logic [XLEN-3:0] base;                        // Word aligned base
            logic [1:0]      mode;                        // Direct or vectored
        } f;
    } trap_vec_t;

endpackage

//--- hw/core_mmio_mux.sv
/*
 * Data bus splitter
 * Steers each core data request to the external port or the MMIO block
 */

`timescale 1ns/10ps

module core_mmio_mux import core_pkg::*; (
    // Core side request
    input  logic                  i_dmem_req,     // Request
    input  logic [XLEN-1:0]       i_dmem_addr,    // Request address
    input  logic                  i_dmem_wen,     // Write enable
    input  logic [MEM_STRB_W-1:0] i_dmem_strb,    // Write strobes
    input  logic [XLEN-1:0]       i_dmem_wdata,   // Write data
    output logic                  o_dmem_gnt,     // Grant
    output logic                  o_dmem_err,     // Error, valid with grant
    output logic [XLEN-1:0]       o_dmem_rdata,   // Read data, valid with grant

    // External memory port
    output logic                  o_ext_req,      // Request
    output logic [XLEN-1:0]       o_ext_addr,     // Request address
    output logic                  o_ext_wen,      // Write enable
    output logic [MEM_STRB_W-1:0] o_ext_strb,     // Write strobes
    output logic [XLEN-1:0]       o_ext_wdata,    // Write data
    input  logic                  i_ext_gnt,      // Grant
    input  logic                  i_ext_err,      // Error
    input  logic [XLEN-1:0]       i_ext_rdata,    // Read data

    // Internal MMIO block
    output logic                  o_mmio_req,     // Request
    output logic                  o_mmio_wen,     // Write enable
    output logic [XLEN-1:0]       o_mmio_addr,    // Request address
    output logic [XLEN-1:0]       o_mmio_wdata,   // Write data, whole words
    input  logic                  i_mmio_gnt,     // Grant
    input  logic                  i_mmio_err,     // Error
    input  logic [XLEN-1:0]       i_mmio_rdata    // Read data
);

    // Region decode
    // --------------------------------------------------
    logic region_hit;                              // Address inside MMIO window

    // Address is held until grant, so this also picks the responder
    assign region_hit = (i_dmem_addr & MMIO_MATCH_MASK) == MMIO_BASE_ADDR;

    // Request steering
    // --------------------------------------------------
    assign o_ext_req    = i_dmem_req && !region_hit;   // Never for region hits
    assign o_ext_addr   = i_dmem_addr;
    assign o_ext_wen    = i_dmem_wen;
    assign o_ext_strb   = i_dmem_strb;
    assign o_ext_wdata  = i_dmem_wdata;

    assign o_mmio_req   = i_dmem_req && region_hit;    // Only for region hits
    assign o_mmio_wen   = i_dmem_wen;
    assign o_mmio_addr  = i_dmem_addr;
    assign o_mmio_wdata = i_dmem_wdata;                // Strobes dropped here

    // Response return
    // --------------------------------------------------
    assign o_dmem_gnt   = region_hit ? i_mmio_gnt   : i_ext_gnt;
    assign o_dmem_err   = region_hit ? i_mmio_err   : i_ext_err;
    assign o_dmem_rdata = region_hit ? i_mmio_rdata : i_ext_rdata;

endmodule

//--- hw/core_counters.sv
/*
 * Free running time counter, compare register and retired instruction
 * counter, with their MMIO register access and the timer interrupt
 */

`timescale 1ns/10ps

module core_counters import core_pkg::*; (
    input  logic            g_clk,          // Global clock
    input  logic            i_rst,          // Sync reset, active high
    input  logic            i_instr_ret,    // One instruction retired
    input  logic            i_mmio_req,     // MMIO request
    input  logic            i_mmio_wen,     // MMIO write enable
    input  logic [XLEN-1:0] i_mmio_addr,    // MMIO address
    input  logic [XLEN-1:0] i_mmio_wdata,   // MMIO write data
    output logic            o_mmio_gnt,     // MMIO grant, one cycle
    output logic            o_mmio_err,     // MMIO error
    output logic [XLEN-1:0] o_mmio_rdata,   // MMIO read data
    output logic            o_timer_int     // Registered timer interrupt
);

    logic [CTR_W-1:0]      mtime_q;         // Time counter
    logic [CTR_W-1:0]      mtimecmp_q;      // Timer compare value
    logic [CTR_W-1:0]      instret_q;       // Retired instruction count
    logic                  gnt_q;           // Grant register
    logic                  timer_int_q;     // Compare result, registered

    logic [MMIO_OFS_W-1:0] ofs;             // Offset within region
    logic [XLEN-1:0]       rd_word;         // Selected register half
    logic                  listed;          // Offset is a known register
    logic                  writable;        // Offset accepts writes
    logic                  acc_ok;          // Access allowed
    logic                  wr_en;           // Write commits this edge

    // Register decode
    // --------------------------------------------------
    assign ofs = i_mmio_addr[MMIO_OFS_W-1:0];

    always_comb begin
        rd_word  = '0;
        listed   = 1'b1;
        writable = 1'b1;
        case (ofs)
            MMIO_OFS_MTIME_LO:    rd_word = mtime_q[XLEN-1:0];
            MMIO_OFS_MTIME_HI:    rd_word = mtime_q[CTR_W-1:XLEN];
            MMIO_OFS_MTIMECMP_LO: rd_word = mtimecmp_q[XLEN-1:0];
            MMIO_OFS_MTIMECMP_HI: rd_word = mtimecmp_q[CTR_W-1:XLEN];
            MMIO_OFS_INSTRET_LO: begin
                rd_word  = instret_q[XLEN-1:0];
                writable = 1'b0;            // Read only
            end
            MMIO_OFS_INSTRET_HI: begin
                rd_word  = instret_q[CTR_W-1:XLEN];
                writable = 1'b0;            // Read only
            end
            default: begin
                listed   = 1'b0;            // Hole in the map
                writable = 1'b0;
            end
        endcase
    end

    assign acc_ok = listed && (!i_mmio_wen || writable);
    assign wr_en  = gnt_q && i_mmio_req && i_mmio_wen && acc_ok;   // At grant edge

    // Bus response
    // --------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (i_rst) begin
            gnt_q <= 1'b0;
        end else begin
            gnt_q <= i_mmio_req && !gnt_q;  // Grant one cycle after request
        end
    end

    assign o_mmio_gnt   = gnt_q;
    assign o_mmio_err   = gnt_q && !acc_ok;
    assign o_mmio_rdata = acc_ok ? rd_word : '0;    // Zero on error

    // Counters
    // --------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (i_rst) begin
            mtime_q <= '0;
        end else if (wr_en && ofs == MMIO_OFS_MTIME_LO) begin
            mtime_q[XLEN-1:0] <= i_mmio_wdata;       // Write replaces increment
        end else if (wr_en && ofs == MMIO_OFS_MTIME_HI) begin
            mtime_q[CTR_W-1:XLEN] <= i_mmio_wdata;
        end else begin
            mtime_q <= mtime_q + CTR_W'(1);
        end
    end

    always_ff @(posedge g_clk) begin
        if (i_rst) begin
            mtimecmp_q <= '1;                        // Timer idle out of reset
        end else if (wr_en && ofs == MMIO_OFS_MTIMECMP_LO) begin
            mtimecmp_q[XLEN-1:0] <= i_mmio_wdata;
        end else if (wr_en && ofs == MMIO_OFS_MTIMECMP_HI) begin
            mtimecmp_q[CTR_W-1:XLEN] <= i_mmio_wdata;
        end
    end

    always_ff @(posedge g_clk) begin
        if (i_rst) begin
            instret_q <= '0;
        end else if (i_instr_ret) begin
            instret_q <= instret_q + CTR_W'(1);
        end
    end

    // Timer interrupt
    // --------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (i_rst) begin
            timer_int_q <= 1'b0;
        end else begin
            timer_int_q <= mtime_q >= mtimecmp_q;    // Level, follows compare
        end
    end

    assign o_timer_int = timer_int_q;

endmodule

//--- hw/core_interrupts.sv
/*
 * Interrupt pending registers and priority selection
 * Produces the cause code and the trap vector of the winning source
 */

`timescale 1ns/10ps

module core_interrupts import core_pkg::*; (
    input  logic               g_clk,           // Global clock
    input  logic               i_rst,           // Sync reset, active high
    input  logic               i_int_sw,        // Software interrupt source
    input  logic               i_int_ext,       // External interrupt source
    input  logic               i_int_ti,        // Timer interrupt source
    input  logic               i_mstatus_mie,   // Global enable
    input  logic               i_mie_msie,      // Software enable
    input  logic               i_mie_mtie,      // Timer enable
    input  logic               i_mie_meie,      // External enable
    input  trap_vec_t          i_mtvec,         // Trap vector word
    output logic               o_int_pending,   // Some interrupt taken
    output logic [CAUSE_W-1:0] o_int_cause,     // Cause of winner, else 0
    output logic [XLEN-1:0]    o_int_tvec       // Trap target address
);

    logic            msip_q;                    // Software pending
    logic            mtip_q;                    // Timer pending
    logic            meip_q;                    // External pending
    logic            take_sw;
    logic            take_ti;
    logic            take_ext;
    logic [XLEN-1:0] tvec_base;                 // Base with low bits cleared

    // Sampled every edge, so sources show up one cycle later
    always_ff @(posedge g_clk) begin
        if (i_rst) begin
            msip_q <= 1'b0;
            mtip_q <= 1'b0;
            meip_q <= 1'b0;
        end else begin
            msip_q <= i_int_sw;
            mtip_q <= i_int_ti;
            meip_q <= i_int_ext;
        end
    end

    // Per source and global enable both needed
    assign take_sw  = msip_q && i_mie_msie && i_mstatus_mie;
    assign take_ti  = mtip_q && i_mie_mtie && i_mstatus_mie;
    assign take_ext = meip_q && i_mie_meie && i_mstatus_mie;

    assign o_int_pending = take_sw || take_ti || take_ext;

    // Priority
    // --------------------------------------------------
    always_comb begin
        if (take_ext) begin
            o_int_cause = CAUSE_MEI;            // Highest
        end else if (take_sw) begin
            o_int_cause = CAUSE_MSI;
        end else if (take_ti) begin
            o_int_cause = CAUSE_MTI;            // Lowest
        end else begin
            o_int_cause = '0;
        end
    end

    // Trap vector, driven even when idle
    // --------------------------------------------------
    assign tvec_base = {i_mtvec.f.base, 2'b00};

    always_comb begin
        case (i_mtvec.f.mode)
            MTVEC_MODE_DIRECT:   o_int_tvec = tvec_base;
            MTVEC_MODE_VECTORED: o_int_tvec = tvec_base + (XLEN'(o_int_cause) << 2);
            default:             o_int_tvec = tvec_base;   // Reserved modes as direct
        endcase
    end

endmodule

//--- hw/core_periph.sv
/*
 * Peripheral top of the core data bus
 * Bus splitter, timer and counter block, interrupt unit
 */

`timescale 1ns/10ps

module core_periph import core_pkg::*; (
    input  logic                  g_clk,          // Global clock
    input  logic                  i_rst,          // Sync reset, active high
    input  logic                  i_instr_ret,    // Instruction retired strobe
    input  logic                  i_int_sw,       // Software interrupt
    input  logic                  i_int_ext,      // External interrupt
    input  logic                  i_mstatus_mie,  // Global interrupt enable
    input  logic                  i_mie_msie,     // Software enable
    input  logic                  i_mie_mtie,     // Timer enable
    input  logic                  i_mie_meie,     // External enable
    input  logic [XLEN-1:0]       i_mtvec,        // Trap vector word from CSRs

    input  logic                  i_dmem_req,     // Core data request
    input  logic [XLEN-1:0]       i_dmem_addr,
    input  logic                  i_dmem_wen,
    input  logic [MEM_STRB_W-1:0] i_dmem_strb,
    input  logic [XLEN-1:0]       i_dmem_wdata,
    output logic                  o_dmem_gnt,     // Core data response
    output logic                  o_dmem_err,
    output logic [XLEN-1:0]       o_dmem_rdata,

    output logic                  o_ext_req,      // External memory request
    output logic [XLEN-1:0]       o_ext_addr,
    output logic                  o_ext_wen,
    output logic [MEM_STRB_W-1:0] o_ext_strb,
    output logic [XLEN-1:0]       o_ext_wdata,
    input  logic                  i_ext_gnt,      // External memory response
    input  logic                  i_ext_err,
    input  logic [XLEN-1:0]       i_ext_rdata,

    output logic                  o_int_pending,  // Interrupt to take
    output logic [CAUSE_W-1:0]    o_int_cause,
    output logic [XLEN-1:0]       o_int_tvec
);

    logic            mmio_req;                    // Splitter to counters
    logic            mmio_wen;
    logic [XLEN-1:0] mmio_addr;
    logic [XLEN-1:0] mmio_wdata;
    logic            mmio_gnt;                    // Counters back to splitter
    logic            mmio_err;
    logic [XLEN-1:0] mmio_rdata;
    logic            timer_int;                   // Compare hit, registered

    // Data bus split
    // --------------------------------------------------
    core_mmio_mux u_mmio_mux (
        .i_dmem_req  (i_dmem_req),  .i_dmem_addr (i_dmem_addr), .i_dmem_wen  (i_dmem_wen),
        .i_dmem_strb (i_dmem_strb), .i_dmem_wdata(i_dmem_wdata),
        .o_dmem_gnt  (o_dmem_gnt),  .o_dmem_err  (o_dmem_err),  .o_dmem_rdata(o_dmem_rdata),
        .o_ext_req   (o_ext_req),   .o_ext_addr  (o_ext_addr),  .o_ext_wen   (o_ext_wen),
        .o_ext_strb  (o_ext_strb),  .o_ext_wdata (o_ext_wdata),
        .i_ext_gnt   (i_ext_gnt),   .i_ext_err   (i_ext_err),   .i_ext_rdata (i_ext_rdata),
        .o_mmio_req  (mmio_req),    .o_mmio_wen  (mmio_wen),    .o_mmio_addr (mmio_addr),
        .o_mmio_wdata(mmio_wdata),
        .i_mmio_gnt  (mmio_gnt),    .i_mmio_err  (mmio_err),    .i_mmio_rdata(mmio_rdata)
    );

    // Timers and counters
    // --------------------------------------------------
    core_counters u_counters (
        .g_clk       (g_clk),       .i_rst       (i_rst),       .i_instr_ret (i_instr_ret),
        .i_mmio_req  (mmio_req),    .i_mmio_wen  (mmio_wen),    .i_mmio_addr (mmio_addr),
        .i_mmio_wdata(mmio_wdata),
        .o_mmio_gnt  (mmio_gnt),    .o_mmio_err  (mmio_err),    .o_mmio_rdata(mmio_rdata),
        .o_timer_int (timer_int)
    );

    // Interrupt unit, mtvec word reinterpreted as the union
    // --------------------------------------------------
    core_interrupts u_interrupts (
        .g_clk        (g_clk),         .i_rst        (i_rst),
        .i_int_sw     (i_int_sw),      .i_int_ext    (i_int_ext),  .i_int_ti     (timer_int),
        .i_mstatus_mie(i_mstatus_mie), .i_mie_msie   (i_mie_msie), .i_mie_mtie   (i_mie_mtie),
        .i_mie_meie   (i_mie_meie),    .i_mtvec      (trap_vec_t'(i_mtvec)),
        .o_int_pending(o_int_pending), .o_int_cause  (o_int_cause), .o_int_tvec  (o_int_tvec)
    );

endmodule

//--- testbench/tb_core_periph.sv
/*
 * Testbench for the core peripheral top
 * Clock, reset, external memory responder, reference models, checks
 */

`timescale 1ns/10ps

module tb_core_periph import core_pkg::*; ();

    localparam int MAX_CYCLES = 6000;             // Run limit in clock cycles

    logic g_clk, i_rst, i_instr_ret;
    logic i_int_sw, i_int_ext, i_mstatus_mie, i_mie_msie, i_mie_mtie, i_mie_meie;
    logic [31:0] i_mtvec;
    logic i_dmem_req, i_dmem_wen, o_dmem_gnt, o_dmem_err;
    logic [31:0] i_dmem_addr, i_dmem_wdata, o_dmem_rdata;
    logic [3:0] i_dmem_strb, o_ext_strb;
    logic o_ext_req, o_ext_wen, i_ext_gnt, i_ext_err;
    logic [31:0] o_ext_addr, o_ext_wdata, i_ext_rdata;
    logic o_int_pending;
    logic [3:0] o_int_cause;
    logic [31:0] o_int_tvec;

    logic [31:0] lfsr;                            // Shared random state
    logic        region_acc;                      // Current access targets MMIO
    int          ext_grants;                      // External grants seen
    int          cycles;                          // Timeout counter

    core_periph UUT (.*);

    // Clock and run limit
    // --------------------------------------------------
    initial begin
        g_clk = 1'b0;
        forever #5 g_clk = ~g_clk;
    end

    always @(posedge g_clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Run timed out after %0d cycles", cycles);
            $display("SOME TESTS FAILED");
            $fatal(1, "Timeout");
        end
    end

    // Helpers and reference models
    // --------------------------------------------------
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};          // One step per bit
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return val;
    endfunction

    function automatic logic [31:0] ext_data(input logic [31:0] addr);
        return addr ^ 32'h5A5A_C3C3;              // Memory contents model
    endfunction

    // Returns {pending, cause, vector}
    function automatic logic [36:0] int_ref(input logic sw, ext, ti, gie, msie, mtie, meie,
                                            input logic [31:0] mtvec);
        logic       t_sw, t_ti, t_ext;
        logic [3:0] cause;
        logic [31:0] base;
        t_sw  = sw && msie && gie;
        t_ti  = ti && mtie && gie;
        t_ext = ext && meie && gie;
        cause = t_ext ? 4'd11 : t_sw ? 4'd3 : t_ti ? 4'd7 : 4'd0;   // Ext, sw, timer
        base  = {mtvec[31:2], 2'b00};
        return {t_sw || t_ti || t_ext, cause,
                (mtvec[1:0] == 2'd1) ? base + {26'd0, cause, 2'b00} : base};
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            $display("SOME TESTS FAILED");
            $fatal(1, "Mismatch");
        end
    endtask

    task automatic bus_access(input logic [31:0] addr, input logic wen, input logic [3:0] strb,
                              input logic [31:0] wdata, output logic err,
                              output logic [31:0] rdata);
        @(negedge g_clk);
        region_acc   = (addr & 32'hFFFF_F000) == 32'h0000_1000;
        i_dmem_req   = 1'b1;
        i_dmem_addr  = addr;
        i_dmem_wen   = wen;
        i_dmem_strb  = strb;
        i_dmem_wdata = wdata;
        do @(posedge g_clk); while (!o_dmem_gnt);   // Held until grant
        err   = o_dmem_err;
        rdata = o_dmem_rdata;
        @(negedge g_clk);
        i_dmem_req = 1'b0;
        i_dmem_wen = 1'b0;
        region_acc = 1'b0;
    endtask

    task automatic read_check(input string name, input logic [31:0] addr,
                              input logic exp_err, input logic [31:0] exp_data);
        logic        err;
        logic [31:0] data;
        bus_access(addr, 1'b0, 4'hF, 32'd0, err, data);
        check_value({name, " err"}, exp_err, err);
        check_value({name, " rdata"}, exp_data, data);
    endtask

    task automatic write_check(input string name, input logic [31:0] addr,
                               input logic [31:0] data, input logic exp_err);
        logic        err;
        logic [31:0] rdata;
        bus_access(addr, 1'b1, 4'hF, data, err, rdata);
        check_value({name, " err"}, exp_err, err);
    endtask

    // External memory responder and bus monitor
    // --------------------------------------------------
    initial begin : ext_responder
        int delay;
        forever begin
            @(posedge g_clk);
            if (o_ext_req && !i_rst) begin
                delay = rand_bits(2);             // 0 to 3 cycles
                repeat (delay) @(posedge g_clk);
                @(negedge g_clk);
                i_ext_gnt   = 1'b1;
                i_ext_err   = o_ext_addr >= 32'h8000_0000;
                i_ext_rdata = ext_data(o_ext_addr);
                @(negedge g_clk);
                i_ext_gnt   = 1'b0;
                i_ext_err   = 1'b0;
                i_ext_rdata = '0;
            end
        end
    end

    always @(posedge g_clk) begin
        if (!i_rst) begin
            assert (!(region_acc && o_ext_req)) else begin
                $display("External request raised during an MMIO region access");
                $display("SOME TESTS FAILED");
                $fatal(1, "Region leak");
            end
            if (o_ext_req && i_ext_gnt) begin     // Port mirrors the request
                ext_grants = ext_grants + 1;
                check_value("ext addr", i_dmem_addr, o_ext_addr);
                check_value("ext wen", i_dmem_wen, o_ext_wen);
                check_value("ext strb", i_dmem_strb, o_ext_strb);
                check_value("ext wdata", i_dmem_wdata, o_ext_wdata);
            end
        end
    end

    // Stimulus
    // --------------------------------------------------
    initial begin
        logic [31:0] addr, wdata, rdata, cmp_lo, cmp_hi, t_lo, t_hi, rnd;
        logic [63:0] target;
        logic [36:0] exp;
        logic [3:0]  strb;
        logic        wen, err;
        int          ret_count, waited;
        lfsr          = 32'h17787578;
        cycles        = 0;
        ext_grants    = 0;
        region_acc    = 1'b0;
        ret_count     = 0;
        i_rst         = 1'b1;
        i_instr_ret   = 1'b0;
        i_int_sw      = 1'b0;
        i_int_ext     = 1'b0;
        i_mstatus_mie = 1'b0;
        i_mie_msie    = 1'b0;
        i_mie_mtie    = 1'b0;
        i_mie_meie    = 1'b0;
        i_mtvec       = '0;
        i_dmem_req    = 1'b0;
        i_dmem_addr   = '0;
        i_dmem_wen    = 1'b0;
        i_dmem_strb   = '0;
        i_dmem_wdata  = '0;
        i_ext_gnt     = 1'b0;
        i_ext_err     = 1'b0;
        i_ext_rdata   = '0;
        repeat (4) @(posedge g_clk);
        @(negedge g_clk);
        i_rst = 1'b0;

        // Reset values
        read_check("mtimecmp lo reset", 32'h1008, 1'b0, 32'hFFFF_FFFF);
        read_check("mtimecmp hi reset", 32'h100C, 1'b0, 32'hFFFF_FFFF);
        read_check("instret lo reset", 32'h1010, 1'b0, 32'd0);
        read_check("instret hi reset", 32'h1014, 1'b0, 32'd0);
        check_value("pending reset", 1'b0, o_int_pending);

        // Compare register write and read back
        cmp_lo = rand_bits(32);
        cmp_hi = rand_bits(32);
        write_check("mtimecmp lo write", 32'h1008, cmp_lo, 1'b0);
        write_check("mtimecmp hi write", 32'h100C, cmp_hi, 1'b0);
        read_check("mtimecmp lo readback", 32'h1008, 1'b0, cmp_lo);
        read_check("mtimecmp hi readback", 32'h100C, 1'b0, cmp_hi);
        write_check("mtimecmp hi idle", 32'h100C, 32'hFFFF_FFFF, 1'b0);
        write_check("mtimecmp lo idle", 32'h1008, 32'hFFFF_FFFF, 1'b0);

        // Retired instruction counter
        for (int i = 0; i < 24; i++) begin
            @(negedge g_clk);
            i_instr_ret = rand_bits(1);
            ret_count   = ret_count + i_instr_ret;   // Counted per cycle held
        end
        @(negedge g_clk);
        i_instr_ret = 1'b0;
        read_check("instret lo", 32'h1010, 1'b0, ret_count);
        read_check("instret hi", 32'h1014, 1'b0, 32'd0);
        write_check("instret write", 32'h1010, 32'hDEAD_0000, 1'b1);
        read_check("instret after write", 32'h1010, 1'b0, ret_count);
        read_check("hole 0x18", 32'h1018, 1'b1, 32'd0);

        // External accesses
        for (int i = 0; i < 40; i++) begin
            rnd  = rand_bits(30);
            addr = {rnd[29:0], 2'b00};
            if ((addr & 32'hFFFF_F000) == 32'h0000_1000) addr[20] = 1'b1;   // Out of region
            wen   = rand_bits(1);
            strb  = rand_bits(4);
            wdata = rand_bits(32);
            bus_access(addr, wen, strb, wdata, err, rdata);
            check_value("ext err", addr >= 32'h8000_0000, err);
            if (!wen) check_value("ext rdata", ext_data(addr), rdata);
        end
        check_value("ext grant count", 32'd40, ext_grants);

        // Software and external interrupts
        for (int i = 0; i < 24; i++) begin
            @(negedge g_clk);
            i_int_sw      = rand_bits(1);
            i_int_ext     = rand_bits(1);
            i_mstatus_mie = rand_bits(1);
            i_mie_msie    = rand_bits(1);
            i_mie_mtie    = rand_bits(1);
            i_mie_meie    = rand_bits(1);
            rnd           = rand_bits(31);
            i_mtvec       = {rnd[30:1], 1'b0, rnd[0]};   // Direct or vectored
            repeat (2) @(posedge g_clk);
            exp = int_ref(i_int_sw, i_int_ext, 1'b0, i_mstatus_mie, i_mie_msie,
                          i_mie_mtie, i_mie_meie, i_mtvec);
            check_value("int pending", exp[36], o_int_pending);
            check_value("int cause", exp[35:32], o_int_cause);
            check_value("int tvec", exp[31:0], o_int_tvec);
        end

        // Timer interrupt
        @(negedge g_clk);
        i_int_sw      = 1'b0;
        i_int_ext     = 1'b0;
        i_mstatus_mie = 1'b1;
        i_mie_msie    = 1'b0;
        i_mie_mtie    = 1'b1;
        i_mie_meie    = 1'b0;
        bus_access(32'h1000, 1'b0, 4'hF, 32'd0, err, t_lo);
        bus_access(32'h1004, 1'b0, 4'hF, 32'd0, err, t_hi);
        target = {t_hi, t_lo} + 64'd20;
        write_check("mtimecmp hi target", 32'h100C, target[63:32], 1'b0);
        write_check("mtimecmp lo target", 32'h1008, target[31:0], 1'b0);
        check_value("timer early", 1'b0, o_int_pending);
        waited = 0;
        while (!o_int_pending && waited < 40) begin
            @(posedge g_clk);
            waited = waited + 1;
        end
        assert (o_int_pending) else begin
            $display("Timer interrupt not raised within 40 cycles");
            $display("SOME TESTS FAILED");
            $fatal(1, "Timer");
        end
        exp = int_ref(1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0, i_mtvec);
        check_value("timer cause", exp[35:32], o_int_cause);
        check_value("timer tvec", exp[31:0], o_int_tvec);
        write_check("mtimecmp hi release", 32'h100C, 32'hFFFF_FFFF, 1'b0);
        write_check("mtimecmp lo release", 32'h1008, 32'hFFFF_FFFF, 1'b0);
        waited = 0;
        while (o_int_pending && waited < 3) begin
            @(posedge g_clk);
            waited = waited + 1;
        end
        assert (!o_int_pending) else begin
            $display("Timer interrupt still pending 3 cycles after compare release");
            $display("SOME TESTS FAILED");
            $fatal(1, "Timer");
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- list.f
hw/core_pkg.sv
hw/core_mmio_mux.sv
hw/core_counters.sv
hw/core_interrupts.sv
hw/core_periph.sv
testbench/tb_core_periph.sv
